// ==== verilog/siudp_config.svh ====
`ifndef SIUDP_CONFIG_SVH
`define SIUDP_CONFIG_SVH

// Address and port the bridge answers on
`define SIUDP_LOCAL_IP {8'd192, 8'd168, 8'd1, 8'd128}
`define SIUDP_PORT 16'd1234

// Request command codes
`define SIUDP_RD_CMD 8'h01
`define SIUDP_WR_CMD 8'h02

// Command byte, size and address
`define SIUDP_HDR_BYTES 4'd9

// Largest reply payload per datagram
`define SIUDP_MAX_PAYLOAD 16'd1476

`endif

// ==== verilog/siudp_pkg.sv ====
package siudp_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] xfer_len_t;
    typedef logic [15:0] udp_len_t;

    // Request header, byte 0 first on the wire and in the MSBs
    typedef union packed {
        // Filled one byte at a time while the header streams in
        logic [0:8][7:0] bytes;
        // Decoded view, size and address are big-endian
        struct packed {
            logic [7:0] cmd;
            xfer_len_t  size;
            bus_addr_t  addr;
        } f;
    } req_hdr_u;

    // Who asked, so the reply can be addressed back
    typedef struct packed {
        ip_addr_t  src_ip;
        udp_port_t src_port;
        udp_port_t dest_port;
    } peer_t;

endpackage

// ==== verilog/siudp_if.sv ====
`timescale 1ns/1ps

// Parsed request from decode to execute
interface siudp_req_if;
    import siudp_pkg::*;

    logic     req_valid;
    logic     req_ready;
    req_hdr_u hdr;
    peer_t    peer;
    // High while decode passes write payload through to execute
    logic     wr_phase;

    modport source (
        output req_valid,
        output hdr,
        output peer,
        output wr_phase,
        input  req_ready
    );

    modport sink (
        input  req_valid,
        input  hdr,
        input  peer,
        input  wr_phase,
        output req_ready
    );
endinterface

// Reply jobs and their bytes from execute to result
interface siudp_reply_if;
    import siudp_pkg::*;

    logic       job_valid;
    logic       job_ready;
    xfer_len_t  job_len;
    peer_t      job_peer;
    logic       beat_valid;
    logic       beat_ready;
    logic [7:0] beat_data;

    modport source (
        output job_valid,
        output job_len,
        output job_peer,
        input  job_ready,
        output beat_valid,
        output beat_data,
        input  beat_ready
    );

    modport sink (
        input  job_valid,
        input  job_len,
        input  job_peer,
        output job_ready,
        input  beat_valid,
        input  beat_data,
        output beat_ready
    );
endinterface

// ==== verilog/siudp_decode.sv ====
`timescale 1ns/1ps
`include "siudp_config.svh"

module siudp_decode (
    input  logic                 clk_125mhz,
    input  logic                 rst_125mhz,
    input  logic                 rx_hdr_valid,
    output logic                 rx_hdr_ready,
    input  siudp_pkg::ip_addr_t  rx_dest_ip,
    input  siudp_pkg::ip_addr_t  rx_src_ip,
    input  siudp_pkg::udp_port_t rx_src_port,
    input  siudp_pkg::udp_port_t rx_dest_port,
    input  logic [7:0]           rx_payload_tdata,
    input  logic                 rx_payload_tvalid,
    input  logic                 rx_payload_tlast,
    output logic                 rx_payload_tready,
    siudp_req_if.source          req
);
    import siudp_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR,
        S_OFFER,
        S_WDATA,
        S_DRAIN
    } state_t;

    state_t     state;
    logic [3:0] hdr_cnt;
    req_hdr_u   hdr_q;
    peer_t      peer_q;
    logic       more_q;
    logic       rx_fire;
    logic       hdr_end;
    logic       cmd_ok;

    // New datagrams wait until execute has finished the previous one
    assign rx_hdr_ready = !rst_125mhz && (state == S_IDLE) && req.req_ready;
    assign rx_payload_tready = (state == S_HDR) || (state == S_WDATA) || (state == S_DRAIN);
    assign rx_fire = rx_payload_tvalid && rx_payload_tready;
    assign hdr_end = (state == S_HDR) && rx_fire && (hdr_cnt == `SIUDP_HDR_BYTES - 4'd1);

    // Command and size are complete by the time the last address byte arrives
    always_comb begin
        case (hdr_q.f.cmd)
            `SIUDP_RD_CMD: cmd_ok = (hdr_q.f.size != '0);
            `SIUDP_WR_CMD: cmd_ok = !rx_payload_tlast;
            default:       cmd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state   <= S_IDLE;
            hdr_cnt <= '0;
            more_q  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    hdr_cnt <= '0;
                    if (rx_hdr_valid && rx_hdr_ready) begin
                        if (rx_dest_ip == `SIUDP_LOCAL_IP && rx_dest_port == `SIUDP_PORT)
                            state <= S_HDR;
                        else
                            state <= S_DRAIN;
                    end
                end
                S_HDR: begin
                    if (rx_fire) begin
                        hdr_cnt <= hdr_cnt + 4'd1;
                        if (hdr_end) begin
                            more_q <= !rx_payload_tlast;
                            if (cmd_ok)
                                state <= S_OFFER;
                            else
                                state <= rx_payload_tlast ? S_IDLE : S_DRAIN;
                        end else if (rx_payload_tlast) begin
                            // Datagram too short for a header
                            state <= S_IDLE;
                        end
                    end
                end
                S_OFFER: begin
                    if (req.req_ready) begin
                        if (hdr_q.f.cmd == `SIUDP_WR_CMD)
                            state <= S_WDATA;
                        else
                            state <= more_q ? S_DRAIN : S_IDLE;
                    end
                end
                S_WDATA, S_DRAIN: begin
                    if (rx_fire && rx_payload_tlast)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rx_hdr_valid && rx_hdr_ready) begin
            peer_q.src_ip    <= rx_src_ip;
            peer_q.src_port  <= rx_src_port;
            peer_q.dest_port <= rx_dest_port;
        end
        if (state == S_HDR && rx_fire)
            hdr_q.bytes[hdr_cnt] <= rx_payload_tdata;
    end

    assign req.req_valid = (state == S_OFFER);
    assign req.hdr       = hdr_q;
    assign req.peer      = peer_q;
    assign req.wr_phase  = (state == S_WDATA);

endmodule

// ==== verilog/siudp_execute.sv ====
`timescale 1ns/1ps
`include "siudp_config.svh"

module siudp_execute (
    input  logic                 clk_125mhz,
    input  logic                 rst_125mhz,
    siudp_req_if.sink            req,
    input  logic [7:0]           rx_payload_tdata,
    input  logic                 rx_payload_tvalid,
    input  logic                 rx_payload_tlast,
    siudp_reply_if.source        reply,
    output siudp_pkg::bus_addr_t bus_addr,
    output logic [7:0]           bus_wdata,
    input  logic [7:0]           bus_rdata,
    output logic                 bus_rd,
    output logic                 bus_wr
);
    import siudp_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_CONFIRM
    } state_t;

    state_t     state;
    bus_addr_t  addr_q;
    // Reads still to issue, or bytes written so far
    xfer_len_t  cnt_q;
    peer_t      peer_q;
    logic       job_pend;
    logic       rd_pend;
    logic       hold_valid;
    logic [7:0] hold_data;
    logic [1:0] conf_idx;
    logic       req_fire;
    logic       is_rd;
    logic       job_fire;
    logic       beat_fire;

    assign req.req_ready = (state == S_IDLE);
    assign req_fire = req.req_valid && req.req_ready;
    assign is_rd = (req.hdr.f.cmd == `SIUDP_RD_CMD);

    // Read job length is the full size until the first read goes out
    assign reply.job_valid = job_pend;
    assign reply.job_len   = (state == S_CONFIRM) ? 32'd4 : cnt_q;
    assign reply.job_peer  = peer_q;
    assign job_fire = reply.job_valid && reply.job_ready;

    // Holding register is older than the byte on the bus
    assign reply.beat_valid = (state == S_CONFIRM) ? !job_pend : (hold_valid || rd_pend);
    assign reply.beat_data = (state == S_CONFIRM) ? cnt_q[{~conf_idx, 3'b000} +: 8] :
                             (hold_valid ? hold_data : bus_rdata);
    assign beat_fire = reply.beat_valid && reply.beat_ready;

    assign bus_addr  = addr_q;
    assign bus_wdata = rx_payload_tdata;
    assign bus_wr    = (state == S_WRITE) && req.wr_phase && rx_payload_tvalid;
    // Only read when the returning byte is sure to find the holding slot empty
    assign bus_rd = (state == S_READ) && !job_pend && (cnt_q != '0) &&
                    !((hold_valid || rd_pend) && !beat_fire);

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state      <= S_IDLE;
            job_pend   <= 1'b0;
            rd_pend    <= 1'b0;
            hold_valid <= 1'b0;
            conf_idx   <= '0;
        end else begin
            rd_pend <= bus_rd;
            if (job_fire)
                job_pend <= 1'b0;
            if (rd_pend && !beat_fire)
                hold_valid <= 1'b1;
            else if (beat_fire)
                hold_valid <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (req_fire) begin
                        job_pend <= is_rd;
                        state    <= is_rd ? S_READ : S_WRITE;
                    end
                end
                S_READ: begin
                    // Nothing left to issue, so this beat is the final one
                    if (cnt_q == '0 && beat_fire)
                        state <= S_IDLE;
                end
                S_WRITE: begin
                    if (bus_wr && rx_payload_tlast) begin
                        job_pend <= 1'b1;
                        conf_idx <= '0;
                        state    <= S_CONFIRM;
                    end
                end
                S_CONFIRM: begin
                    if (beat_fire) begin
                        conf_idx <= conf_idx + 2'd1;
                        if (conf_idx == 2'd3)
                            state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (req_fire) begin
            addr_q <= req.hdr.f.addr;
            cnt_q  <= is_rd ? req.hdr.f.size : '0;
            peer_q <= req.peer;
        end else if (bus_rd) begin
            addr_q <= addr_q + 32'd1;
            cnt_q  <= cnt_q - 32'd1;
        end else if (bus_wr) begin
            addr_q <= addr_q + 32'd1;
            cnt_q  <= cnt_q + 32'd1;
        end
        if (rd_pend && !beat_fire)
            hold_data <= bus_rdata;
    end

endmodule

// ==== verilog/siudp_result.sv ====
`timescale 1ns/1ps
`include "siudp_config.svh"

module siudp_result (
    input  logic                 clk_125mhz,
    input  logic                 rst_125mhz,
    siudp_reply_if.sink          reply,
    output logic                 tx_hdr_valid,
    input  logic                 tx_hdr_ready,
    output siudp_pkg::ip_addr_t  tx_dest_ip,
    output siudp_pkg::udp_port_t tx_src_port,
    output siudp_pkg::udp_port_t tx_dest_port,
    output siudp_pkg::udp_len_t  tx_length,
    output logic [7:0]           tx_payload_tdata,
    output logic                 tx_payload_tvalid,
    output logic                 tx_payload_tlast,
    input  logic                 tx_payload_tready
);
    import siudp_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR,
        S_DATA
    } state_t;

    state_t    state;
    // Bytes left in the whole job
    xfer_len_t left_q;
    // Bytes left in the current packet
    udp_len_t  pkt_left;
    peer_t     peer_q;
    logic      beat_fire;

    assign reply.job_ready = (state == S_IDLE);

    // Reply goes back where the request came from
    assign tx_hdr_valid = (state == S_HDR);
    assign tx_dest_ip   = peer_q.src_ip;
    assign tx_src_port  = peer_q.dest_port;
    assign tx_dest_port = peer_q.src_port;
    assign tx_length    = (left_q > `SIUDP_MAX_PAYLOAD) ? `SIUDP_MAX_PAYLOAD :
                          udp_len_t'(left_q);

    assign tx_payload_tvalid = (state == S_DATA) && reply.beat_valid;
    assign tx_payload_tdata  = reply.beat_data;
    assign tx_payload_tlast  = (pkt_left == 16'd1);
    assign reply.beat_ready  = (state == S_DATA) && tx_payload_tready;
    assign beat_fire = tx_payload_tvalid && tx_payload_tready;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (reply.job_valid)
                        state <= S_HDR;
                end
                S_HDR: begin
                    if (tx_hdr_ready)
                        state <= S_DATA;
                end
                S_DATA: begin
                    // More than one byte left means another packet follows
                    if (beat_fire && tx_payload_tlast)
                        state <= (left_q == 32'd1) ? S_IDLE : S_HDR;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (state == S_IDLE && reply.job_valid) begin
            left_q <= reply.job_len;
            peer_q <= reply.job_peer;
        end else if (beat_fire) begin
            left_q <= left_q - 32'd1;
        end

        if (state == S_HDR && tx_hdr_ready)
            pkt_left <= tx_length;
        else if (beat_fire)
            pkt_left <= pkt_left - 16'd1;
    end

endmodule

// ==== verilog/siudp_bridge.sv ====
`timescale 1ns/1ps

module siudp_bridge (
    input  logic                 clk_125mhz,
    input  logic                 rst_125mhz,

    // Parsed UDP receive stream
    input  logic                 rx_hdr_valid,
    output logic                 rx_hdr_ready,
    input  siudp_pkg::ip_addr_t  rx_dest_ip,
    input  siudp_pkg::ip_addr_t  rx_src_ip,
    input  siudp_pkg::udp_port_t rx_src_port,
    input  siudp_pkg::udp_port_t rx_dest_port,
    input  logic [7:0]           rx_payload_tdata,
    input  logic                 rx_payload_tvalid,
    input  logic                 rx_payload_tlast,
    output logic                 rx_payload_tready,

    // UDP transmit stream, source IP is filled in downstream
    output logic                 tx_hdr_valid,
    input  logic                 tx_hdr_ready,
    output siudp_pkg::ip_addr_t  tx_dest_ip,
    output siudp_pkg::udp_port_t tx_src_port,
    output siudp_pkg::udp_port_t tx_dest_port,
    output siudp_pkg::udp_len_t  tx_length,
    output logic [7:0]           tx_payload_tdata,
    output logic                 tx_payload_tvalid,
    output logic                 tx_payload_tlast,
    input  logic                 tx_payload_tready,

    // Register bus
    output siudp_pkg::bus_addr_t bus_addr,
    output logic [7:0]           bus_wdata,
    input  logic [7:0]           bus_rdata,
    output logic                 bus_rd,
    output logic                 bus_wr
);

    siudp_req_if   req_if ();
    siudp_reply_if reply_if ();

    siudp_decode u_decode (
        .clk_125mhz        (clk_125mhz),
        .rst_125mhz        (rst_125mhz),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_dest_ip        (rx_dest_ip),
        .rx_src_ip         (rx_src_ip),
        .rx_src_port       (rx_src_port),
        .rx_dest_port      (rx_dest_port),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tready (rx_payload_tready),
        .req               (req_if.source)
    );

    // Write data comes straight off the receive stream
    siudp_execute u_execute (
        .clk_125mhz        (clk_125mhz),
        .rst_125mhz        (rst_125mhz),
        .req               (req_if.sink),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tlast  (rx_payload_tlast),
        .reply             (reply_if.source),
        .bus_addr          (bus_addr),
        .bus_wdata         (bus_wdata),
        .bus_rdata         (bus_rdata),
        .bus_rd            (bus_rd),
        .bus_wr            (bus_wr)
    );

    siudp_result u_result (
        .clk_125mhz        (clk_125mhz),
        .rst_125mhz        (rst_125mhz),
        .reply             (reply_if.sink),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_dest_ip        (tx_dest_ip),
        .tx_src_port       (tx_src_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tready (tx_payload_tready)
    );

endmodule

// ==== dv/siudp_bridge_tb.sv ====
`timescale 1ns/1ps
`include "siudp_config.svh"

module siudp_bridge_tb;
    import siudp_pkg::*;

    localparam int HDR = `SIUDP_HDR_BYTES;
    // Bytes on the rx side and bytes expected back over all tests
    localparam int SENT_BYTES = (HDR + 20) + HDR + HDR + 3 * HDR + HDR + (HDR + 32) + HDR;
    localparam int EXP_BYTES = 4 + 16 + 3000 + 16 + 4 + 32;
    localparam int CYCLE_LIMIT = 4 * (SENT_BYTES + EXP_BYTES) + 2000;
    localparam ip_addr_t SRC_IP = {8'd192, 8'd168, 8'd1, 8'd10};
    localparam ip_addr_t OTHER_IP = {8'd192, 8'd168, 8'd1, 8'd129};

    logic       clk_125mhz;
    logic       rst_125mhz;
    logic       rx_hdr_valid;
    logic       rx_hdr_ready;
    ip_addr_t   rx_dest_ip;
    ip_addr_t   rx_src_ip;
    udp_port_t  rx_src_port;
    udp_port_t  rx_dest_port;
    logic [7:0] rx_payload_tdata;
    logic       rx_payload_tvalid;
    logic       rx_payload_tlast;
    logic       rx_payload_tready;
    logic       tx_hdr_valid;
    logic       tx_hdr_ready = 1'b0;
    ip_addr_t   tx_dest_ip;
    udp_port_t  tx_src_port;
    udp_port_t  tx_dest_port;
    udp_len_t   tx_length;
    logic [7:0] tx_payload_tdata;
    logic       tx_payload_tvalid;
    logic       tx_payload_tlast;
    logic       tx_payload_tready = 1'b0;
    bus_addr_t  bus_addr;
    logic [7:0] bus_wdata;
    logic [7:0] bus_rdata = 8'h00;
    logic       bus_rd;
    logic       bus_wr;

    // Bus memory model and the expected memory contents
    logic [7:0] mem [0:65535];
    logic [7:0] shadow [0:65535];
    logic [15:0] rd_addr_q;
    logic        rd_hit_q = 1'b0;

    // Expected packets with one header entry per packet
    udp_len_t   exp_len[$];
    ip_addr_t   exp_ip[$];
    udp_port_t  exp_sport[$];
    udp_port_t  exp_dport[$];
    logic [7:0] exp_data[$];
    bit         exp_last[$];
    logic [7:0] wr_data[$];
    bit         pkt_open = 1'b0;
    bit         bp_en = 1'b0;
    int         cycle_cnt = 0;

    siudp_bridge dut (.*);

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped on error");
    endtask

    function automatic logic [7:0] fill_byte(input int a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h5a;
    endfunction

    // Expected reply packets for one request
    function automatic void expect_reply(input bit is_read, input xfer_len_t count,
            input bus_addr_t addr, input ip_addr_t src_ip, input udp_port_t src_port);
        xfer_len_t left;
        udp_len_t  len;
        bus_addr_t a;
        int        n;
        left = is_read ? count : 32'd4;
        a = addr;
        while (left != 0) begin
            len = (left > xfer_len_t'(`SIUDP_MAX_PAYLOAD)) ? `SIUDP_MAX_PAYLOAD : udp_len_t'(left);
            n = int'(len);
            exp_len.push_back(len);
            exp_ip.push_back(src_ip);
            exp_sport.push_back(`SIUDP_PORT);
            exp_dport.push_back(src_port);
            for (int i = 0; i < n; i++) begin
                if (is_read) begin
                    exp_data.push_back(shadow[a[15:0]]);
                    a = a + 32'd1;
                end else begin
                    // Byte count goes most significant byte first
                    exp_data.push_back(count[(3 - i) * 8 +: 8]);
                end
                exp_last.push_back(i == n - 1);
            end
            left = left - xfer_len_t'(len);
        end
    endfunction

    task automatic check_hdr(input udp_len_t len, exp_len_v, input udp_port_t sport, exp_sport_v,
            input udp_port_t dport, exp_dport_v, input ip_addr_t ip, exp_ip_v);
        if (len !== exp_len_v)
            abort_run($sformatf("mismatch at %0t: tx_length got %0d expected %0d",
                $time, len, exp_len_v));
        else if (sport !== exp_sport_v)
            abort_run($sformatf("mismatch at %0t: tx_src_port got %0d expected %0d",
                $time, sport, exp_sport_v));
        else if (dport !== exp_dport_v)
            abort_run($sformatf("mismatch at %0t: tx_dest_port got %0d expected %0d",
                $time, dport, exp_dport_v));
        else if (ip !== exp_ip_v)
            abort_run($sformatf("mismatch at %0t: tx_dest_ip got %08h expected %08h",
                $time, ip, exp_ip_v));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %02h expected %02h",
                $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_memory(input bus_addr_t addr, input int n);
        bus_addr_t a;
        for (int i = 0; i < n; i++) begin
            a = addr + bus_addr_t'(i);
            check_byte($sformatf("mem[%04h]", a[15:0]), mem[a[15:0]], shadow[a[15:0]]);
        end
    endtask

    // Header handshake followed by the request header and wr_data bytes
    task automatic send_request(input logic [7:0] cmd, input xfer_len_t size,
            input bus_addr_t addr, input ip_addr_t dest_ip, input udp_port_t dest_port,
            input udp_port_t src_port);
        logic [7:0] bytes[$];
        bytes.push_back(cmd);
        for (int i = 3; i >= 0; i--)
            bytes.push_back(size[i * 8 +: 8]);
        for (int i = 3; i >= 0; i--)
            bytes.push_back(addr[i * 8 +: 8]);
        foreach (wr_data[i])
            bytes.push_back(wr_data[i]);
        @(negedge clk_125mhz);
        rx_hdr_valid = 1'b1;
        rx_dest_ip = dest_ip;
        rx_src_ip = SRC_IP;
        rx_src_port = src_port;
        rx_dest_port = dest_port;
        @(posedge clk_125mhz);
        while (!rx_hdr_ready)
            @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < bytes.size(); i++) begin
            rx_payload_tdata = bytes[i];
            rx_payload_tvalid = 1'b1;
            rx_payload_tlast = (i == bytes.size() - 1);
            @(posedge clk_125mhz);
            while (!rx_payload_tready)
                @(posedge clk_125mhz);
            @(negedge clk_125mhz);
        end
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast = 1'b0;
    endtask

    task automatic run_read(input int n, input bus_addr_t addr);
        udp_port_t sp;
        sp = udp_port_t'($urandom);
        wr_data.delete();
        expect_reply(1'b1, xfer_len_t'(n), addr, SRC_IP, sp);
        send_request(`SIUDP_RD_CMD, xfer_len_t'(n), addr, `SIUDP_LOCAL_IP, `SIUDP_PORT, sp);
    endtask

    task automatic run_write(input int n, input bus_addr_t addr);
        udp_port_t sp;
        bus_addr_t a;
        sp = udp_port_t'($urandom);
        wr_data.delete();
        for (int i = 0; i < n; i++) begin
            a = addr + bus_addr_t'(i);
            wr_data.push_back(8'($urandom));
            shadow[a[15:0]] = wr_data[i];
        end
        expect_reply(1'b0, xfer_len_t'(n), addr, SRC_IP, sp);
        send_request(`SIUDP_WR_CMD, xfer_len_t'(n), addr, `SIUDP_LOCAL_IP, `SIUDP_PORT, sp);
    endtask

    task automatic wait_replies();
        while (exp_len.size() != 0 || exp_data.size() != 0)
            @(posedge clk_125mhz);
    endtask

    // Register bus model with read data valid the cycle after bus_rd
    always @(posedge clk_125mhz) begin
        if (bus_wr)
            mem[bus_addr[15:0]] = bus_wdata;
        rd_hit_q <= bus_rd;
        rd_addr_q <= bus_addr[15:0];
    end

    always @(negedge clk_125mhz) begin
        if (rd_hit_q)
            bus_rdata = mem[rd_addr_q];
        tx_hdr_ready = bp_en ? (($urandom % 4) != 0) : 1'b1;
        tx_payload_tready = bp_en ? (($urandom % 4) != 0) : 1'b1;
    end

    always @(posedge clk_125mhz) begin
        if (!rst_125mhz) begin
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_len.size() == 0) begin
                    abort_run("tx header appeared while no reply was expected");
                end else begin
                    check_hdr(tx_length, exp_len.pop_front(), tx_src_port, exp_sport.pop_front(),
                        tx_dest_port, exp_dport.pop_front(), tx_dest_ip, exp_ip.pop_front());
                    pkt_open = 1'b1;
                end
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                if (!pkt_open || exp_data.size() == 0) begin
                    abort_run("tx payload byte appeared outside an expected packet");
                end else begin
                    check_byte("tx_payload_tdata", tx_payload_tdata, exp_data.pop_front());
                    check_flag("tx_payload_tlast", tx_payload_tlast, exp_last.pop_front());
                    if (tx_payload_tlast)
                        pkt_open = 1'b0;
                end
            end
        end
    end

    always @(posedge clk_125mhz) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
            abort_run($sformatf("timeout after %0d cycles, replies still outstanding", cycle_cnt));
    end

    initial begin
        void'($urandom(14));
        rst_125mhz = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_dest_ip = '0;
        rx_src_ip = '0;
        rx_src_port = '0;
        rx_dest_port = '0;
        rx_payload_tdata = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_byte(a);
            shadow[a] = fill_byte(a);
        end
        repeat (16) @(negedge clk_125mhz);
        // Handshake and strobe outputs stay low while reset is held
        check_flag("rx_hdr_ready", rx_hdr_ready, 1'b0);
        check_flag("rx_payload_tready", rx_payload_tready, 1'b0);
        check_flag("tx_hdr_valid", tx_hdr_valid, 1'b0);
        check_flag("tx_payload_tvalid", tx_payload_tvalid, 1'b0);
        check_flag("bus_rd", bus_rd, 1'b0);
        check_flag("bus_wr", bus_wr, 1'b0);
        rst_125mhz = 1'b0;

        run_write(20, 32'h0000_0100);
        wait_replies();
        check_memory(32'h0000_0100, 20);
        // Overlaps the bytes just written
        run_read(16, 32'h0000_0104);
        wait_replies();

        // Splits into 1476, 1476 and 48
        bp_en = 1'b1;
        run_read(3000, 32'h0000_8000);
        wait_replies();
        bp_en = 1'b0;

        // None of these filtered datagrams may reply
        wr_data.delete();
        send_request(`SIUDP_RD_CMD, 32'd16, 32'h0000_4000, `SIUDP_LOCAL_IP,
            `SIUDP_PORT + 16'd1, 16'd5000);
        send_request(`SIUDP_RD_CMD, 32'd16, 32'h0000_4000, OTHER_IP, `SIUDP_PORT, 16'd5000);
        send_request(8'h07, 32'd16, 32'h0000_4000, `SIUDP_LOCAL_IP, `SIUDP_PORT, 16'd5000);
        repeat (50) @(posedge clk_125mhz);
        run_read(16, 32'h0000_4000);
        wait_replies();

        // Read right behind the write of the same range
        run_write(32, 32'h0000_2000);
        run_read(32, 32'h0000_2000);
        wait_replies();
        check_memory(32'h0000_2000, 32);

        if (exp_len.size() == 0 && exp_data.size() == 0 && !pkt_open) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("replies still outstanding at the end of the run");
        end
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/siudp_pkg.sv
verilog/siudp_if.sv
verilog/siudp_decode.sv
verilog/siudp_execute.sv
verilog/siudp_result.sv
verilog/siudp_bridge.sv
dv/siudp_bridge_tb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := siudp_bridge_tb
FILELIST := list.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
